// ==== common/memops_cfg.svh ====
/* load/store sizing */
`ifndef MEMOPS_CFG_SVH
`define MEMOPS_CFG_SVH

// width of the outstanding counter
// also the log2 depth of the return FIFO in the bus master
`define MEM_LGDEPTH 4

// the most requests the issue gate lets into flight at once
// has to stay below the return FIFO depth
`define MEM_MAXDEPTH 6

// word address width of the block RAM
// any word address with bits above this set gets a bus error
`define MEM_RAM_AW 10

`endif

// ==== common/memops_pkg.sv ====
/* load/store unit types */
package memops_pkg;

	// memory opcode as the CPU issues it
	// bit 0 marks a store and bits 2:1 carry the access size
	typedef enum logic [2:0] {
		OP_LB = 3'b010,
		OP_SB = 3'b011,
		OP_LH = 3'b100,
		OP_SH = 3'b101,
		OP_LW = 3'b110,
		OP_SW = 3'b111
	} mem_op_e;

	// access size, the same encoding as opcode bits 2:1
	typedef enum logic [1:0] {
		SZ_NONE = 2'b00,
		SZ_BYTE = 2'b01,
		SZ_HALF = 2'b10,
		SZ_WORD = 2'b11
	} mem_size_e;

	// response sequencing inside the block RAM slave
	typedef enum logic [1:0] {
		RAM_IDLE,
		RAM_ACK,
		RAM_ERR
	} ram_state_e;

	// register tag, bit 4 is the mode and 14/15 are CC and PC
	typedef logic [4:0] reg_id_t;

	// what the bus master remembers about each request in flight
	typedef struct packed {
		reg_id_t   wreg;
		mem_size_e size;
		logic [1:0] lsb;
		logic      store;
	} ret_entry_t;

endpackage

// ==== common/mem_if.sv ====
/* CPU side request and response */
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// one accepted request, strobed for a single cycle
//////////////////////////////////////////////////////////////////////
interface mem_req_if;
	import memops_pkg::*;

	// stb is a one-cycle pulse, never held and never back-pressured
	logic        stb;
	mem_op_e     op;
	logic [31:0] addr;
	logic [31:0] data;
	reg_id_t     oreg;

	// the issue gate drives the request
	modport master (
		output stb, op, addr, data, oreg
	);

	// the bus master consumes it
	modport sink (
		input stb, op, addr, data, oreg
	);

	// bookkeeping only watches
	modport monitor (
		input stb, op, addr, data, oreg
	);
endinterface

//////////////////////////////////////////////////////////////////////
// responses and status from the bus master
//////////////////////////////////////////////////////////////////////
interface mem_rsp_if;
	import memops_pkg::*;

	// done pulses for every finished request
	// valid comes with done on loads only
	logic        valid;
	logic        done;
	// err ends the whole string, done and valid stay low with it
	logic        err;
	reg_id_t     wreg;
	logic [31:0] result;
	// levels, anything in flight and a load in flight
	logic        busy;
	logic        rdbusy;

	modport source (
		output valid, done, err, wreg, result, busy, rdbusy
	);

	modport monitor (
		input valid, done, err, wreg, result, busy, rdbusy
	);
endinterface

// ==== common/wb_bus_if.sv ====
/* pipelined bus */
`timescale 1ns/1ps

interface wb_bus_if;
	// a transfer happens on stb with stall low
	// ack or err come back in order, one per transfer
	logic        cyc;
	logic        stb;
	logic        we;
	// word address, byte lanes picked by sel
	logic [29:0] addr;
	logic [3:0]  sel;
	logic [31:0] wdata;
	logic        stall;
	logic        ack;
	logic        err;
	logic [31:0] rdata;

	modport master (
		output cyc, stb, we, addr, sel, wdata,
		input  stall, ack, err, rdata
	);

	// dropping cyc on the master side cancels whatever the slave owes
	modport slave (
		input  cyc, stb, we, addr, sel, wdata,
		output stall, ack, err, rdata
	);
endinterface

// ==== source/mem_issue.sv ====
/* issue gate */
`timescale 1ns/1ps
`include "memops_cfg.svh"

module mem_issue (
	input  logic                    i_clk,
	input  logic                    i_cpu_reset,
	input  logic                    i_stb,
	input  memops_pkg::mem_op_e     i_op,
	input  logic [31:0]             i_addr,
	input  logic [31:0]             i_data,
	input  memops_pkg::reg_id_t     i_oreg,
	output logic                    o_pipe_stalled,
	mem_req_if.master               req,
	mem_rsp_if.monitor              rsp,
	input  logic [`MEM_LGDEPTH-1:0] i_outstanding,
	input  logic                    i_read_cycle,
	input  logic                    i_pc_pending,
	input  logic                    i_gie
);
	logic [`MEM_LGDEPTH:0] count_eff;
	logic                  busy_eff;
	logic                  read_eff;
	logic                  gie_eff;
	logic                  pc_eff;
	logic                  accept;

	// the tracker only sees our strobe on the following edge
	// so the request sitting in req this cycle is folded in here
	assign busy_eff  = rsp.busy || req.stb;
	assign read_eff  = req.stb ? !req.op[0] : i_read_cycle;
	assign gie_eff   = req.stb ? req.oreg[4] : i_gie;
	assign count_eff = {1'b0, i_outstanding} + {{`MEM_LGDEPTH{1'b0}}, req.stb};
	// a load into CC or PC blocks everything behind it
	assign pc_eff    = i_pc_pending || (req.stb && !req.op[0] && (req.oreg[3:1] == 3'b111));

	// stalled as a level whether or not the CPU is asking
	assign o_pipe_stalled = rsp.err
		|| pc_eff
		|| (count_eff >= `MEM_MAXDEPTH)
		|| (busy_eff && (read_eff != !i_op[0]))
		|| (busy_eff && (gie_eff != i_oreg[4]));

	assign accept = i_stb && !o_pipe_stalled;

	always_ff @(posedge i_clk)
	begin
		if (i_cpu_reset)
			req.stb <= 1'b0;
		else
			req.stb <= accept;
	end

	// request fields only move when something is taken
	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			req.op   <= i_op;
			req.addr <= i_addr;
			req.data <= i_data;
			req.oreg <= i_oreg;
		end
	end

endmodule

// ==== mem_unit/mem_pipeline.sv ====
/* pipelined bus master */
`timescale 1ns/1ps
`include "memops_cfg.svh"

module mem_pipeline (
	input  logic      i_clk,
	input  logic      i_cpu_reset,
	mem_req_if.sink   req,
	mem_rsp_if.source rsp,
	wb_bus_if.master  wb
);
	import memops_pkg::*;

	localparam int FIFO_DEPTH = 1 << `MEM_LGDEPTH;

	ret_entry_t              ret_fifo [0:FIFO_DEPTH-1];
	logic [`MEM_LGDEPTH-1:0] wr_ptr;
	logic [`MEM_LGDEPTH-1:0] rd_ptr;
	logic [`MEM_LGDEPTH-1:0] next_count;
	logic                    push;
	logic                    pop;
	logic                    flush;
	mem_size_e               req_size;
	ret_entry_t              head;
	logic [3:0]              lane_sel;
	logic [31:0]             lane_data;
	logic [31:0]             shifted;
	logic [31:0]             aligned;

	//////////////////////////////////////////////////////////////////////
	// request side
	//////////////////////////////////////////////////////////////////////

	// a bus error flushes the edge it is seen on and the err cycle after
	assign flush = wb.cyc && wb.err;
	assign pop   = wb.cyc && wb.ack;
	assign push  = req.stb && !flush && !rsp.err && !(wb.stb && wb.stall);

	assign req_size = mem_size_e'(req.op[2:1]);

	// lanes are little endian, lane 0 is bits 7:0
	always_comb
	begin
		case (req_size)
		SZ_BYTE:
		begin
			lane_sel  = 4'b0001 << req.addr[1:0];
			lane_data = {4{req.data[7:0]}};
		end
		SZ_HALF:
		begin
			lane_sel  = req.addr[1] ? 4'b1100 : 4'b0011;
			lane_data = {2{req.data[15:0]}};
		end
		default:
		begin
			lane_sel  = 4'b1111;
			lane_data = req.data;
		end
		endcase
	end

	assign next_count = wr_ptr - rd_ptr + {{(`MEM_LGDEPTH-1){1'b0}}, push}
		- {{(`MEM_LGDEPTH-1){1'b0}}, pop};

	// cyc stays up until the last response is back
	always_ff @(posedge i_clk)
	begin
		if (i_cpu_reset || flush)
		begin
			wb.cyc <= 1'b0;
			wb.stb <= 1'b0;
		end
		else
		begin
			wb.cyc <= (next_count != '0);
			if (!wb.stb || !wb.stall)
				wb.stb <= push;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (push)
		begin
			wb.we    <= req.op[0];
			wb.addr  <= req.addr[31:2];
			wb.sel   <= lane_sel;
			wb.wdata <= lane_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// return FIFO, tag and alignment for each transfer
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk)
	begin
		if (push)
			ret_fifo[wr_ptr] <= '{wreg: req.oreg, size: req_size,
				lsb: req.addr[1:0], store: req.op[0]};
	end

	always_ff @(posedge i_clk)
	begin
		if (i_cpu_reset || flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// response side
	//////////////////////////////////////////////////////////////////////
	assign head    = ret_fifo[rd_ptr];
	assign shifted = wb.rdata >> {head.lsb, 3'b000};

	// loads zero extend
	always_comb
	begin
		case (head.size)
		SZ_BYTE:
			aligned = {24'h0, shifted[7:0]};
		SZ_HALF:
			aligned = {16'h0, shifted[15:0]};
		default:
			aligned = wb.rdata;
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (i_cpu_reset)
		begin
			rsp.valid <= 1'b0;
			rsp.done  <= 1'b0;
			rsp.err   <= 1'b0;
		end
		else
		begin
			rsp.valid <= pop && !head.store;
			rsp.done  <= pop;
			rsp.err   <= flush;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (pop)
		begin
			rsp.wreg   <= head.wreg;
			rsp.result <= aligned;
		end
	end

	// a string never mixes directions, so we tells a load string apart
	assign rsp.busy   = wb.cyc;
	assign rsp.rdbusy = wb.cyc && !wb.we;

endmodule

// ==== mem_unit/mem_tracker.sv ====
/* request tracker */
`timescale 1ns/1ps
`include "memops_cfg.svh"

module mem_tracker (
	input  logic                    i_clk,
	input  logic                    i_cpu_reset,
	mem_req_if.monitor              req,
	mem_rsp_if.monitor              rsp,
	output logic [`MEM_LGDEPTH-1:0] o_outstanding,
	output logic                    o_read_cycle,
	output logic                    o_pc_pending,
	output logic                    o_gie
);
	logic req_special;
	logic rsp_special;

	// tags 14 and 15 in either mode, CC and PC
	assign req_special = req.stb && !req.op[0] && (req.oreg[3:1] == 3'b111);
	assign rsp_special = rsp.valid && (rsp.wreg[3:1] == 3'b111);

	//////////////////////////////////////////////////////////////////////
	// outstanding count
	//////////////////////////////////////////////////////////////////////

	// a request in the err cycle was already dropped by the bus master
	always_ff @(posedge i_clk)
	begin
		if (i_cpu_reset || rsp.err)
			o_outstanding <= '0;
		else
		begin
			case ({req.stb, rsp.done})
			2'b10:
				o_outstanding <= o_outstanding + 1'b1;
			2'b01:
				o_outstanding <= o_outstanding - 1'b1;
			default:
				o_outstanding <= o_outstanding;
			endcase
		end
	end

	// direction of the current string
	always_ff @(posedge i_clk)
	begin
		if (i_cpu_reset || rsp.err)
			o_read_cycle <= 1'b0;
		else if (req.stb)
			o_read_cycle <= !req.op[0];
		else if (!rsp.busy)
			o_read_cycle <= 1'b0;
	end

	// special register load in flight
	always_ff @(posedge i_clk)
	begin
		if (i_cpu_reset || rsp.err)
			o_pc_pending <= 1'b0;
		else if (req_special)
			o_pc_pending <= 1'b1;
		else if (rsp_special)
			o_pc_pending <= 1'b0;
	end

	// mode that owns the string, taken from the tag
	always_ff @(posedge i_clk)
	begin
		if (i_cpu_reset)
			o_gie <= 1'b0;
		else if (req.stb)
			o_gie <= req.oreg[4];
	end

endmodule

// ==== source/bus_ram.sv ====
/* block RAM bus slave */
`timescale 1ns/1ps
`include "memops_cfg.svh"

module bus_ram (
	input  logic    i_clk,
	input  logic    i_cpu_reset,
	wb_bus_if.slave wb
);
	import memops_pkg::*;

	localparam int RAM_WORDS = 1 << `MEM_RAM_AW;

	logic [31:0]            ram [0:RAM_WORDS-1];
	ram_state_e             state;
	logic [`MEM_RAM_AW-1:0] word_addr;
	logic                   in_range;
	logic                   xfer;

	// single cycle block RAM, never any need to stall
	assign wb.stall  = 1'b0;
	assign word_addr = wb.addr[`MEM_RAM_AW-1:0];
	assign in_range  = (wb.addr[29:`MEM_RAM_AW] == '0);
	// a transfer arriving alongside an err belongs to a dead string
	assign xfer      = wb.cyc && wb.stb && !wb.stall && (state != RAM_ERR);

	// one response per transfer, cancelled once cyc falls
	always_ff @(posedge i_clk)
	begin
		if (i_cpu_reset || !wb.cyc)
			state <= RAM_IDLE;
		else if (xfer)
			state <= in_range ? RAM_ACK : RAM_ERR;
		else
			state <= RAM_IDLE;
	end

	// byte lane writes
	always_ff @(posedge i_clk)
	begin
		if (xfer && in_range && wb.we)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (wb.sel[i])
					ram[word_addr][8*i +: 8] <= wb.wdata[8*i +: 8];
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (xfer)
			wb.rdata <= ram[word_addr];
	end

	assign wb.ack = (state == RAM_ACK);
	assign wb.err = (state == RAM_ERR);

endmodule

// ==== source/mem_subsystem_top.sv ====
/* load/store subsystem */
`timescale 1ns/1ps
`include "memops_cfg.svh"

module mem_subsystem_top (
	input  logic                i_clk,
	input  logic                i_cpu_reset,
	// CPU request
	input  logic                i_stb,
	input  memops_pkg::mem_op_e i_op,
	input  logic [31:0]         i_addr,
	input  logic [31:0]         i_data,
	input  memops_pkg::reg_id_t i_oreg,
	output logic                o_pipe_stalled,
	// status and results
	output logic                o_busy,
	output logic                o_rdbusy,
	output logic                o_valid,
	output logic                o_done,
	output logic                o_err,
	output memops_pkg::reg_id_t o_wreg,
	output logic [31:0]         o_result
);
	logic [`MEM_LGDEPTH-1:0] outstanding;
	logic                    read_cycle;
	logic                    pc_pending;
	logic                    gie;

	mem_req_if req_if ();
	mem_rsp_if rsp_if ();
	wb_bus_if  wb_if ();

	// gate uses the tracker state to decide what may go
	mem_issue u_issue (
		.i_clk          (i_clk),
		.i_cpu_reset    (i_cpu_reset),
		.i_stb          (i_stb),
		.i_op           (i_op),
		.i_addr         (i_addr),
		.i_data         (i_data),
		.i_oreg         (i_oreg),
		.o_pipe_stalled (o_pipe_stalled),
		.req            (req_if.master),
		.rsp            (rsp_if.monitor),
		.i_outstanding  (outstanding),
		.i_read_cycle   (read_cycle),
		.i_pc_pending   (pc_pending),
		.i_gie          (gie)
	);

	mem_pipeline u_pipe (
		.i_clk       (i_clk),
		.i_cpu_reset (i_cpu_reset),
		.req         (req_if.sink),
		.rsp         (rsp_if.source),
		.wb          (wb_if.master)
	);

	mem_tracker u_tracker (
		.i_clk         (i_clk),
		.i_cpu_reset   (i_cpu_reset),
		.req           (req_if.monitor),
		.rsp           (rsp_if.monitor),
		.o_outstanding (outstanding),
		.o_read_cycle  (read_cycle),
		.o_pc_pending  (pc_pending),
		.o_gie         (gie)
	);

	bus_ram u_ram (
		.i_clk       (i_clk),
		.i_cpu_reset (i_cpu_reset),
		.wb          (wb_if.slave)
	);

	// response bundle out to the CPU
	assign o_busy   = rsp_if.busy;
	assign o_rdbusy = rsp_if.rdbusy;
	assign o_valid  = rsp_if.valid;
	assign o_done   = rsp_if.done;
	assign o_err    = rsp_if.err;
	assign o_wreg   = rsp_if.wreg;
	assign o_result = rsp_if.result;

endmodule

// ==== dv/tb_mem_subsystem.sv ====
/* load/store subsystem testbench */
`timescale 1ns/1ps
`include "memops_cfg.svh"

module tb_mem_subsystem;
	import memops_pkg::*;

	localparam int RAM_WORDS   = 1 << `MEM_RAM_AW;
	localparam int RAM_BYTES   = 4 * RAM_WORDS;
	// all in-range traffic stays inside a window that the fill phase writes first
	localparam int FILL_WORDS  = 64;
	localparam int RW_ROUNDS   = 24;
	localparam int BURST_LEN   = 12;
	// 16 for direction and mode, 4 for special loads and 9 for the bus error test
	localparam int DIRECTED    = 29;
	// each write/read round issues at most 6 requests
	localparam int TOTAL_REQ   = FILL_WORDS + RW_ROUNDS * 6 + BURST_LEN + DIRECTED;
	localparam int TIMEOUT     = 2 * TOTAL_REQ * 8;

	logic        i_clk;
	logic        i_cpu_reset;
	logic        i_stb;
	mem_op_e     i_op;
	logic [31:0] i_addr;
	logic [31:0] i_data;
	reg_id_t     i_oreg;
	logic        o_pipe_stalled;
	logic        o_busy;
	logic        o_rdbusy;
	logic        o_valid;
	logic        o_done;
	logic        o_err;
	reg_id_t     o_wreg;
	logic [31:0] o_result;

	// byte image of the RAM with little endian words
	logic [7:0]  model_mem [0:RAM_BYTES-1];
	logic [31:0] lfsr_state;
	int          cycle_cnt;
	int          err_count;
	int          err_pulses;
	int          inflight;
	logic        prev_accept;
	logic        special_returned;
	// direction of the most recently accepted request
	logic        last_store;
	// expected loads in issue order
	reg_id_t     exp_tag_q [$];
	logic [31:0] exp_val_q [$];
	int          exp_edge_q [$];

	mem_subsystem_top u_dut (
		.i_clk          (i_clk),
		.i_cpu_reset    (i_cpu_reset),
		.i_stb          (i_stb),
		.i_op           (i_op),
		.i_addr         (i_addr),
		.i_data         (i_data),
		.i_oreg         (i_oreg),
		.o_pipe_stalled (o_pipe_stalled),
		.o_busy         (o_busy),
		.o_rdbusy       (o_rdbusy),
		.o_valid        (o_valid),
		.o_done         (o_done),
		.o_err          (o_err),
		.o_wreg         (o_wreg),
		.o_result       (o_result)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// the cycle count also bounds the run
	initial cycle_cnt = 0;
	always @(posedge i_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("FAIL: see errors above");
			$fatal(1, "run stopped on timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb)
			s = s ^ 32'h8020_0003;
		return s;
	endfunction

	// one LFSR step per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	function automatic mem_size_e rand_size();
		logic [1:0] s;
		s = rand_bits(2);
		// size code 00 is never issued, so it doubles as a word
		if (s == 2'b00)
			return SZ_WORD;
		return mem_size_e'(s);
	endfunction

	// naturally aligned address inside the filled window
	function automatic logic [31:0] rand_addr(input mem_size_e size);
		logic [31:0] word;
		logic [1:0]  lane;
		word = rand_bits(6);
		case (size)
		SZ_BYTE:
			lane = rand_bits(2);
		SZ_HALF:
			lane = {rand_bits(1) != 0, 1'b0};
		default:
			lane = 2'b00;
		endcase
		return {word[29:0], lane};
	endfunction

	// ordinary register tag that is never CC or PC
	function automatic reg_id_t rand_tag(input logic gie);
		logic [3:0] t;
		t = rand_bits(4);
		if (t[3:1] == 3'b111)
			t[3] = 1'b0;
		return {gie, t};
	endfunction

	// stores update the byte image and loads read it back zero extended
	function automatic logic [31:0] ref_access(input mem_op_e op, input logic [31:0] addr,
		input logic [31:0] data);
		int          nbytes;
		logic [31:0] val;
		val = '0;
		case (op[2:1])
		2'b01:
			nbytes = 1;
		2'b10:
			nbytes = 2;
		default:
			nbytes = 4;
		endcase
		// out of range ends in a bus error and touches nothing
		if (addr[31:2] >= RAM_WORDS)
			return val;
		for (int i = 0; i < nbytes; i++)
		begin
			if (op[0])
				model_mem[addr + i] = data[8*i +: 8];
			else
				val[8*i +: 8] = model_mem[addr + i];
		end
		return val;
	endfunction

	task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
		input string what);
		if (got !== exp)
		begin
			err_count++;
			$display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "stopping at the first error");
		end
	endtask

	// presents one request and holds it until taken
	// called and returns a few ns after a rising edge
	task automatic issue_req(input mem_op_e op, input logic [31:0] addr,
		input logic [31:0] data, input reg_id_t tag, output int stalls,
		output logic busy_seen);
		logic        taken;
		logic [31:0] exp;
		i_stb  = 1'b1;
		i_op   = op;
		i_addr = addr;
		i_data = data;
		i_oreg = tag;
		stalls = 0;
		busy_seen = 1'b0;
		taken = 1'b0;
		while (!taken)
		begin
			@(negedge i_clk);
			if (o_pipe_stalled)
				stalls++;
			else
			begin
				// taken on the coming edge which is edge cycle_cnt + 1
				taken = 1'b1;
				busy_seen = o_busy;
				last_store = op[0];
				exp = ref_access(op, addr, data);
				if (!op[0])
				begin
					exp_tag_q.push_back(tag);
					exp_val_q.push_back(exp);
					exp_edge_q.push_back(cycle_cnt + 1);
				end
			end
			@(posedge i_clk);
			#5;
		end
		i_stb = 1'b0;
	endtask

	task automatic random_req(input logic store, input logic gie, output int stalls);
		mem_size_e   size;
		logic [31:0] addr;
		logic [31:0] data;
		reg_id_t     tag;
		logic        busy_seen;
		size = rand_size();
		addr = rand_addr(size);
		data = rand_bits(32);
		tag  = rand_tag(gie);
		issue_req(mem_op_e'({size, store}), addr, data, tag, stalls, busy_seen);
	endtask

	// a request that has to wait for the string in flight to drain
	task automatic issue_after_drain(input logic store, input logic gie, input string what);
		mem_size_e   size;
		logic [31:0] addr;
		logic [31:0] data;
		reg_id_t     tag;
		int          stalls;
		logic        busy_seen;
		size = rand_size();
		addr = rand_addr(size);
		data = rand_bits(32);
		tag  = rand_tag(gie);
		issue_req(mem_op_e'({size, store}), addr, data, tag, stalls, busy_seen);
		compare_value(stalls > 0, 1, {what, " was stalled"});
		compare_value(busy_seen, 1'b0, {what, " waited for o_busy to fall"});
	endtask

	// waits for a quiet cycle with nothing in flight
	task automatic wait_idle();
		logic quiet;
		quiet = 1'b0;
		while (!quiet)
		begin
			@(negedge i_clk);
			#1;
			quiet = !o_busy && !o_valid && !o_done && !o_err && (inflight == 0)
				&& (exp_val_q.size() == 0);
		end
		@(posedge i_clk);
		#5;
	endtask

	//////////////////////////////////////////////////////////////////////
	// response checking
	//////////////////////////////////////////////////////////////////////
	always @(negedge i_clk)
	begin
		if (!i_cpu_reset)
		begin
			// the gate counts a request from its accept edge until its done
			inflight = inflight + prev_accept;
			compare_value(inflight <= `MEM_MAXDEPTH, 1, "requests in flight within limit");
			if (inflight >= `MEM_MAXDEPTH)
				compare_value(o_pipe_stalled, 1'b1, "stall at the in-flight limit");
			// a string never mixes directions, so the last request names it
			compare_value(o_rdbusy, o_busy && !last_store, "o_rdbusy");
			if (o_valid)
			begin
				compare_value(exp_val_q.size() != 0, 1, "o_valid with a load expected");
				compare_value(o_wreg, exp_tag_q[0], "o_wreg");
				compare_value(o_result, exp_val_q[0], "o_result");
				compare_value(cycle_cnt, exp_edge_q[0] + 3, "load latency edge");
				if (o_wreg[3:1] == 3'b111)
					special_returned = 1'b1;
				void'(exp_tag_q.pop_front());
				void'(exp_val_q.pop_front());
				void'(exp_edge_q.pop_front());
			end
			if (o_err)
			begin
				err_pulses++;
				compare_value(o_pipe_stalled, 1'b1, "o_pipe_stalled in the err cycle");
				compare_value({o_valid, o_done}, 2'b00, "valid and done in the err cycle");
				// the whole string is gone and nothing left will answer
				exp_tag_q.delete();
				exp_val_q.delete();
				exp_edge_q.delete();
				inflight = 0;
			end
			else if (o_done)
				inflight = inflight - 1;
			prev_accept = i_stb && !o_pipe_stalled;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		int          stalls;
		int          n;
		logic        gie;
		logic        busy_seen;
		logic [31:0] bad_addr;
		lfsr_state = 32'hcb15_5228;
		err_count = 0;
		err_pulses = 0;
		inflight = 0;
		prev_accept = 1'b0;
		special_returned = 1'b0;
		last_store = 1'b0;
		i_cpu_reset = 1'b1;
		i_stb = 1'b0;
		i_op = OP_LW;
		i_addr = '0;
		i_data = '0;
		i_oreg = '0;
		repeat (16) @(posedge i_clk);
		#5;
		i_cpu_reset = 1'b0;
		@(negedge i_clk);
		compare_value({o_valid, o_done, o_err, o_busy, o_rdbusy, o_pipe_stalled}, 6'b0,
			"outputs after reset");
		@(posedge i_clk);
		#5;

		// fill the window with words so that every later load is defined
		for (int w = 0; w < FILL_WORDS; w++)
			issue_req(OP_SW, w * 4, rand_bits(32), rand_tag(1'b0), stalls, busy_seen);
		wait_idle();

		// random stores followed by random loads with modes mixed freely
		for (int r = 0; r < RW_ROUNDS; r++)
		begin
			n = 1 + rand_bits(2) % 3;
			gie = rand_bits(1);
			for (int k = 0; k < n; k++)
				random_req(1'b1, gie, stalls);
			n = 1 + rand_bits(2) % 3;
			gie = rand_bits(1);
			for (int k = 0; k < n; k++)
				random_req(1'b0, gie, stalls);
		end
		wait_idle();

		// load burst streams with at most four in flight, so it never stalls
		for (int k = 0; k < BURST_LEN; k++)
		begin
			random_req(1'b0, 1'b0, stalls);
			compare_value(stalls, 0, "stall inside a load burst");
		end
		wait_idle();

		// reads and writes never mix in flight
		for (int k = 0; k < 4; k++)
			random_req(1'b0, 1'b0, stalls);
		issue_after_drain(1'b1, 1'b0, "store after loads");
		for (int k = 0; k < 3; k++)
			random_req(1'b1, 1'b0, stalls);
		issue_after_drain(1'b0, 1'b0, "load after stores");
		wait_idle();

		// mode never changes mid string
		for (int k = 0; k < 3; k++)
			random_req(1'b0, 1'b0, stalls);
		issue_after_drain(1'b0, 1'b1, "load in the other mode");
		wait_idle();
		for (int k = 0; k < 2; k++)
			random_req(1'b1, 1'b1, stalls);
		issue_after_drain(1'b1, 1'b0, "store in the other mode");
		wait_idle();

		// a PC load and then a CC load each hold back a load in the same mode
		special_returned = 1'b0;
		issue_req(OP_LW, rand_addr(SZ_WORD), '0, 5'd15, stalls, busy_seen);
		random_req(1'b0, 1'b0, stalls);
		compare_value(special_returned, 1'b1, "request held until the PC load returned");
		compare_value(stalls > 0, 1, "request behind the PC load was stalled");
		wait_idle();
		special_returned = 1'b0;
		issue_req(OP_LW, rand_addr(SZ_WORD), '0, 5'd30, stalls, busy_seen);
		random_req(1'b0, 1'b1, stalls);
		compare_value(special_returned, 1'b1, "request held until the CC load returned");
		compare_value(stalls > 0, 1, "request behind the CC load was stalled");
		wait_idle();

		// out-of-range load in the middle of a stream
		random_req(1'b0, 1'b0, stalls);
		random_req(1'b0, 1'b0, stalls);
		bad_addr = {rand_bits(20), 12'h000};
		// word address bit 10 puts it past the RAM
		bad_addr[12] = 1'b1;
		issue_req(OP_LW, bad_addr, '0, rand_tag(1'b0), stalls, busy_seen);
		random_req(1'b0, 1'b0, stalls);
		random_req(1'b0, 1'b0, stalls);
		wait_idle();
		compare_value(err_pulses, 1, "bus error pulses after the bad load");
		for (int k = 0; k < 4; k++)
			random_req(1'b0, 1'b0, stalls);
		wait_idle();

		compare_value(err_pulses, 1, "bus error pulses over the run");
		compare_value(exp_val_q.size(), 0, "loads left without a result");
		if (err_count == 0)
		begin
			$display("PASS: all tests");
			$finish;
		end
		else
		begin
			$display("FAIL: see errors above");
			$fatal(1, "errors found during the run");
		end
	end

endmodule

// ==== list.f ====
+incdir+common
common/memops_pkg.sv
common/mem_if.sv
common/wb_bus_if.sv
source/mem_issue.sv
mem_unit/mem_pipeline.sv
mem_unit/mem_tracker.sv
source/bus_ram.sv
source/mem_subsystem_top.sv
dv/tb_mem_subsystem.sv
